// ==== div_unit.f ====
+incdir+src
+incdir+verification
src/div_pkg.sv
src/div_sequencer.sv
src/div_datapath.sv
src/div_ccgen.sv
src/div_unit.sv
verification/div_unit_tb.sv

// ==== verification/div_model.svh ====
/*
 * Divider reference model
 * LCG stimulus source and the expected quotient and icc rule
 */
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// One LCG step, full 32-bit state
function automatic logic [31:0] lcg_step(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// Truncating divide, 32-bit saturation, icc {N, Z, V, C}
function automatic div_pkg::div_result_t model_divide(input div_pkg::div_req_t r);
   logic                       a_neg;
   logic                       b_neg;
   logic                       q_neg;
   logic [`DIV_DIVIDEND_W-1:0] a_mag;
   logic [`DIV_DIVIDEND_W-1:0] b_mag;
   logic [`DIV_DIVIDEND_W-1:0] q_mag;
   logic [`DIV_QUOT_W-1:0]     q;
   logic                       v;
   div_pkg::div_result_t       res;

   // Operand signs only count for signed divides
   a_neg = r.signed_div & r.dividend[`DIV_DIVIDEND_W-1];
   b_neg = r.signed_div & r.divisor[`DIV_DIVISOR_W-1];
   a_mag = a_neg ? (~r.dividend + 64'd1) : r.dividend;
   b_mag = b_neg ? {32'd0, ~r.divisor + 32'd1} : {32'd0, r.divisor};

   // Magnitude divide truncates toward zero
   q_mag = a_mag / b_mag;
   q_neg = a_neg ^ b_neg;

   if (!r.signed_div) begin
      // Must fit in 32 unsigned bits
      v = (q_mag > 64'h0000_0000_FFFF_FFFF);
      q = v ? 32'hFFFF_FFFF : q_mag[31:0];
   end else if (!q_neg) begin
      // Largest positive signed value
      v = (q_mag > 64'h0000_0000_7FFF_FFFF);
      q = v ? 32'h7FFF_FFFF : q_mag[31:0];
   end else begin
      // Negative side reaches one further
      v = (q_mag > 64'h0000_0000_8000_0000);
      q = v ? 32'h8000_0000 : (~q_mag[31:0] + 32'd1);
   end

   res.quotient = q;
   res.icc      = {q[31], (q == '0) & ~v, v, 1'b0};
   return res;
endfunction

`endif

// ==== verification/div_unit_tb.sv ====
/*
 * Divider testbench
 * Random and corner divides with back-pressure and a mid-run kill
 */
`include "div_cfg.svh"

module div_unit_tb;

   localparam int MAX_OPS         = 40;
   localparam int WATCHDOG_CYCLES = MAX_OPS * (`DIV_LATENCY + 16);

   logic                 clk;
   logic                 reset;
   logic                 input_vld;
   div_pkg::div_req_t    req;
   logic                 kill;
   logic                 result_ack;
   logic                 result_req;
   div_pkg::div_result_t result;

   // Expected value taken at issue time
   div_pkg::div_result_t exp_result;
   // Edges since the accepting edge
   int                   lat_cnt;
   logic                 killed;
   logic [31:0]          rand_state;

   `include "div_model.svh"

   div_unit DUT (
      .clk        (clk),
      .reset      (reset),
      .input_vld  (input_vld),
      .req        (req),
      .kill       (kill),
      .result_ack (result_ack),
      .result_req (result_req),
      .result     (result)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Reporting and helpers
   ////////////////////////////////////////
   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("Error: time %0t, %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic report_failure(input string what);
      $display("Error: time %0t, %s", $time, what);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   function automatic logic [31:0] next_rand();
      rand_state = lcg_step(rand_state);
      return rand_state;
   endfunction

   function automatic div_pkg::div_req_t make_req(input logic [63:0] dividend,
                                                  input logic [31:0] divisor,
                                                  input logic        signed_div);
      div_pkg::div_req_t r;
      r.dividend   = dividend;
      r.divisor    = divisor;
      r.signed_div = signed_div;
      return r;
   endfunction

   ////////////////////////////////////////
   // Bookkeeping
   ////////////////////////////////////////

   // Latency count stops once result_req is seen
   always @(posedge clk) begin
      if (reset || kill) begin
         lat_cnt <= 0;
      end else if (input_vld) begin
         lat_cnt <= 1;
      end else if (lat_cnt != 0 && !result_req) begin
         lat_cnt <= lat_cnt + 1;
      end
   end

   // Set by kill until the next issue
   always @(posedge clk) begin
      if (reset) begin
         killed <= 1'b0;
      end else if (kill) begin
         killed <= 1'b1;
      end else if (input_vld) begin
         killed <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_quotient : assert property (@(posedge clk) disable iff (reset)
      result_req |-> (result.quotient == exp_result.quotient))
      else report_mismatch("result.quotient", $sampled(exp_result.quotient),
                           $sampled(result.quotient));

   a_icc : assert property (@(posedge clk) disable iff (reset)
      result_req |-> (result.icc == exp_result.icc))
      else report_mismatch("result.icc", $sampled(exp_result.icc), $sampled(result.icc));

   // First request cycle lands exactly on the latency
   a_latency : assert property (@(posedge clk) disable iff (reset)
      $rose(result_req) |-> (lat_cnt == `DIV_LATENCY))
      else report_mismatch("result_req latency", `DIV_LATENCY, $sampled(lat_cnt));

   a_not_early : assert property (@(posedge clk) disable iff (reset)
      (lat_cnt != 0 && lat_cnt < `DIV_LATENCY) |-> !result_req)
      else report_failure("result_req rose before the expected latency");

   // Back-pressure freezes the request and the result
   a_hold : assert property (@(posedge clk) disable iff (reset)
      (result_req && !result_ack && !kill) |=> (result_req && $stable(result)))
      else report_failure("result_req or result changed while waiting for ack");

   a_release : assert property (@(posedge clk) disable iff (reset)
      (result_req && result_ack && !kill) |=> !result_req)
      else report_failure("result_req stayed high after ack");

   a_killed : assert property (@(posedge clk) disable iff (reset)
      killed |-> !result_req)
      else report_failure("result_req appeared for a killed operation");

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // One-cycle strobe with the expected value set alongside
   task automatic issue_op(input div_pkg::div_req_t r);
      @(posedge clk);
      input_vld  <= 1'b1;
      req        <= r;
      exp_result <= model_divide(r);
      @(posedge clk);
      input_vld <= 1'b0;
   endtask

   // Wait for the request and ack after a random 0 to 8 cycle delay
   task automatic collect_result();
      int          waited;
      logic [31:0] delay;
      waited = 0;
      while (!result_req) begin
         @(posedge clk);
         waited++;
         if (waited > `DIV_LATENCY + 4) begin
            report_failure("no result_req within the expected latency");
         end
      end
      delay = (next_rand() >> 16) % 9;
      repeat (delay) @(posedge clk);
      result_ack <= 1'b1;
      @(posedge clk);
      result_ack <= 1'b0;
   endtask

   task automatic run_op(input div_pkg::div_req_t r);
      issue_op(r);
      collect_result();
   endtask

   initial begin
      logic [31:0] d;
      logic [31:0] q;
      logic [31:0] m;
      logic [63:0] a;
      rand_state = 32'h5258_4f96;
      reset      <= 1'b1;
      input_vld  <= 1'b0;
      req        <= '0;
      kill       <= 1'b0;
      result_ack <= 1'b0;
      exp_result <= '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // Unsigned with dividend below 2^32 times divisor
      repeat (10) begin
         d = next_rand();
         if (d == '0) begin
            d = 32'd1;
         end
         q = next_rand();
         m = next_rand() % d;
         run_op(make_req({32'd0, q} * {32'd0, d} + {32'd0, m}, d, 1'b0));
      end

      // Signed with every sign pairing twice
      for (int i = 0; i < 8; i++) begin
         d = (next_rand() >> 1) | 32'd1;
         q = next_rand() >> 2;
         m = next_rand() % d;
         a = {32'd0, q} * {32'd0, d} + {32'd0, m};
         run_op(make_req(i[0] ? -a : a, i[1] ? -d : d, 1'b1));
      end
      // -5 / 7 truncates to zero
      run_op(make_req(64'hFFFF_FFFF_FFFF_FFFB, 32'd7, 1'b1));

      // Unsigned overflow
      run_op(make_req('1, 32'd1, 1'b0));
      a = {next_rand() | 32'h0001_0000, next_rand()};
      d = (next_rand() & 32'h0000_FFFF) | 32'd1;
      run_op(make_req(a, d, 1'b0));

      // Signed positive overflow with 2^32 and 2^31 results
      run_op(make_req(64'h0000_0001_0000_0000, 32'd1, 1'b1));
      run_op(make_req(64'hFFFF_FFFF_8000_0000, 32'hFFFF_FFFF, 1'b1));
      // Signed negative overflow
      run_op(make_req(64'hFFFF_FF00_0000_0000, 32'd3, 1'b1));
      // Most negative dividend by -1 and by 1
      run_op(make_req(64'h8000_0000_0000_0000, 32'hFFFF_FFFF, 1'b1));
      run_op(make_req(64'h8000_0000_0000_0000, 32'd1, 1'b1));
      // Most negative quotient that still fits
      run_op(make_req(64'h0000_0000_8000_0000, 32'hFFFF_FFFF, 1'b1));

      // Kill mid-run and wait past the latency
      issue_op(make_req(64'd1000, 32'd7, 1'b0));
      repeat (20) @(posedge clk);
      kill <= 1'b1;
      @(posedge clk);
      kill <= 1'b0;
      repeat (`DIV_LATENCY + 8) @(posedge clk);
      run_op(make_req(64'h0000_0012_3456_789A, 32'h0001_0003, 1'b0));

      @(posedge clk);
      $display("STATUS: PASS");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_failure("timeout, the test did not finish within the watchdog limit");
   end

endmodule

// ==== src/div_unit.sv ====
/*
 * Sequential integer divider
 * 64/32 unsigned or signed divide with saturated 32-bit quotient and icc
 */
module div_unit (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 input_vld,
   input  div_pkg::div_req_t    req,
   input  logic                 kill,
   input  logic                 result_ack,
   output logic                 result_req,
   output div_pkg::div_result_t result
);

   // Sequencer to datapath and cc stage
   div_pkg::div_state_e state;
   logic                ld_inputs;

   // Datapath to cc stage
   div_pkg::div_raw_t   raw;

   // FSM, counter and write-back request
   div_sequencer u_sequencer (
      .clk        (clk),
      .reset      (reset),
      .input_vld  (input_vld),
      .kill       (kill),
      .result_ack (result_ack),
      .state      (state),
      .ld_inputs  (ld_inputs),
      .result_req (result_req)
   );

   // Remainder and quotient registers
   div_datapath u_datapath (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .ld_inputs (ld_inputs),
      .req       (req),
      .raw       (raw)
   );

   // Overflow checks, saturation and icc
   div_ccgen u_ccgen (
      .clk    (clk),
      .reset  (reset),
      .state  (state),
      .raw    (raw),
      .result (result)
   );

endmodule

// ==== src/div_ccgen.sv ====
/*
 * Divider condition codes
 * Staged overflow checks, 32-bit saturation and icc generation
 */
`include "div_cfg.svh"

module div_ccgen (
   input  logic                 clk,
   input  logic                 reset,
   input  div_pkg::div_state_e  state,
   input  div_pkg::div_raw_t    raw,
   output div_pkg::div_result_t result
);

   localparam int MSB = `DIV_DIVIDEND_W - 1;

   // Flags staged one cycle in CHK_OVFL
   logic upper32_zero;
   logic upper33_zero;
   logic upper33_one;

   // Overflow select
   logic                   q_neg;
   logic                   unsign_ovfl;
   logic                   pos_ovfl;
   logic                   neg_ovfl;
   logic                   div_v;

   // Final values
   logic [`DIV_QUOT_W-1:0] sat_q;
   logic [3:0]             icc;

   ////////////////////////////////////////
   // Upper-bit checks
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (state == div_pkg::CHK_OVFL) begin
         upper32_zero <= (raw.quotient[MSB:`DIV_QUOT_W] == '0);
         // Bit 31 joins the check for signed results
         upper33_zero <= (raw.quotient[MSB:`DIV_QUOT_W-1] == '0);
         upper33_one  <= &raw.quotient[MSB:`DIV_QUOT_W-1];
      end
   end

   ////////////////////////////////////////
   // Saturation and icc
   ////////////////////////////////////////
   always_comb begin
      // Sign of the full-width quotient
      q_neg = raw.quotient[MSB];

      // Exactly one check applies per operation
      unsign_ovfl = ~raw.signed_div & ~upper32_zero;
      pos_ovfl    = raw.signed_div & ~q_neg & ~upper33_zero;
      neg_ovfl    = raw.signed_div & q_neg & ~upper33_one;
      div_v       = unsign_ovfl | pos_ovfl | neg_ovfl;

      // Clamp to the 32-bit range
      if (unsign_ovfl) begin
         sat_q = '1;
      end else if (pos_ovfl) begin
         sat_q = {1'b0, {(`DIV_QUOT_W-1){1'b1}}};
      end else if (neg_ovfl) begin
         sat_q = {1'b1, {(`DIV_QUOT_W-1){1'b0}}};
      end else begin
         sat_q = raw.quotient[`DIV_QUOT_W-1:0];
      end

      // N
      icc[3] = sat_q[`DIV_QUOT_W-1];
      // Z, never set together with overflow
      icc[2] = (sat_q == '0) & ~div_v;
      // V
      icc[1] = div_v;
      // C, always clear for divide
      icc[0] = 1'b0;
   end

   // Result register, held through DONE
   always_ff @(posedge clk) begin
      if (state == div_pkg::FIX_OVFL) begin
         result.quotient <= sat_q;
         result.icc      <= icc;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Result frozen while write-back is pending
   a_result_stable : assert property (@(posedge clk) disable iff (reset)
      (state == div_pkg::DONE) ##1 (state == div_pkg::DONE) |-> $stable(result));

endmodule

// ==== src/div_datapath.sv ====
/*
 * Divider datapath
 * Restoring shift-subtract on operand magnitudes, sign fix at the end
 */
`include "div_cfg.svh"

module div_datapath (
   input  logic                clk,
   input  logic                reset,
   input  div_pkg::div_state_e state,
   input  logic                ld_inputs,
   input  div_pkg::div_req_t   req,
   output div_pkg::div_raw_t   raw
);

   // Dividend bits shift out the top, quotient bits enter at the bottom
   logic [`DIV_DIVIDEND_W-1:0] dq;
   // Partial remainder, always below the divisor
   logic [`DIV_DIVISOR_W-1:0]  rem;
   logic [`DIV_DIVISOR_W-1:0]  dvsr;

   // Operation flags captured at load
   logic signed_q;
   logic neg_q;

   // Load-side sign handling
   logic                       dividend_neg;
   logic                       divisor_neg;
   logic [`DIV_DIVIDEND_W-1:0] dividend_mag;
   logic [`DIV_DIVISOR_W-1:0]  divisor_mag;

   // One restoring step
   logic [`DIV_DIVISOR_W:0]    shifted;
   logic [`DIV_DIVISOR_W:0]    trial;
   logic                       fits;

   ////////////////////////////////////////
   // Operand magnitudes
   ////////////////////////////////////////
   always_comb begin
      dividend_neg = req.signed_div & req.dividend[`DIV_DIVIDEND_W-1];
      divisor_neg  = req.signed_div & req.divisor[`DIV_DIVISOR_W-1];
      // Most negative values map onto their unsigned magnitude
      dividend_mag = dividend_neg ? -req.dividend : req.dividend;
      divisor_mag  = divisor_neg ? -req.divisor : req.divisor;
   end

   ////////////////////////////////////////
   // Restoring step
   ////////////////////////////////////////
   always_comb begin
      // Bring the next dividend bit into the remainder
      shifted = {rem, dq[`DIV_DIVIDEND_W-1]};
      trial   = shifted - {1'b0, dvsr};
      // No borrow means the divisor goes in
      fits    = (shifted >= {1'b0, dvsr});
   end

   // Iteration registers
   always_ff @(posedge clk) begin
      if (ld_inputs) begin
         dq   <= dividend_mag;
         dvsr <= divisor_mag;
         rem  <= '0;
      end else if (state == div_pkg::RUN) begin
         rem <= fits ? trial[`DIV_DIVISOR_W-1:0] : shifted[`DIV_DIVISOR_W-1:0];
         dq  <= {dq[`DIV_DIVIDEND_W-2:0], fits};
      end else if (state == div_pkg::LAST_CALC) begin
         // Negate the magnitude, this truncates toward zero
         if (neg_q) begin
            dq <= -dq;
         end else if (signed_q && dq[`DIV_DIVIDEND_W-1]) begin
            // Only min/-1 lands here, clamp to the largest positive value
            dq <= {1'b0, {(`DIV_DIVIDEND_W-1){1'b1}}};
         end
      end
   end

   // Sign and mode flags
   always_ff @(posedge clk) begin
      if (reset) begin
         signed_q <= 1'b0;
         neg_q    <= 1'b0;
      end else if (ld_inputs) begin
         signed_q <= req.signed_div;
         neg_q    <= dividend_neg ^ divisor_neg;
      end
   end

   // Stable from the end of LAST_CALC until the next load
   assign raw.quotient   = dq;
   assign raw.signed_div = signed_q;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Zero divisor is not supported by the caller contract
   a_divisor_nonzero : assert property (@(posedge clk) disable iff (reset)
      ld_inputs |-> (req.divisor != '0));

endmodule

// ==== src/div_sequencer.sv ====
/*
 * Divider sequencer
 * One-hot FSM plus iteration counter, owns the write-back request
 */
`include "div_cfg.svh"

module div_sequencer (
   input  logic                clk,
   input  logic                reset,
   input  logic                input_vld,
   input  logic                kill,
   input  logic                result_ack,
   output div_pkg::div_state_e state,
   output logic                ld_inputs,
   output logic                result_req
);

   localparam int CNT_W = $clog2(`DIV_STEPS);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DIV_STEPS - 1);

   div_pkg::div_state_e next_state;
   logic [CNT_W-1:0]    cnt;
   logic                cnt_done;

   ////////////////////////////////////////
   // Output decode
   ////////////////////////////////////////

   // Accept only from idle, a same-cycle kill wins
   assign ld_inputs  = input_vld & (state == div_pkg::IDLE) & ~kill;
   assign result_req = (state == div_pkg::DONE);

   // Last restoring step in flight
   assign cnt_done = (cnt == LAST_CNT);

   ////////////////////////////////////////
   // Next state
   ////////////////////////////////////////
   always_comb begin
      next_state = state;
      case (state)
         div_pkg::IDLE:      if (input_vld) next_state = div_pkg::RUN;
         div_pkg::RUN:       if (cnt_done) next_state = div_pkg::LAST_CALC;
         // Fixed single-cycle stages
         div_pkg::LAST_CALC: next_state = div_pkg::CHK_OVFL;
         div_pkg::CHK_OVFL:  next_state = div_pkg::FIX_OVFL;
         div_pkg::FIX_OVFL:  next_state = div_pkg::DONE;
         // Hold the request until write-back takes it
         div_pkg::DONE:      if (result_ack) next_state = div_pkg::IDLE;
         default:            next_state = div_pkg::IDLE;
      endcase
      // Abort from anywhere
      if (kill) begin
         next_state = div_pkg::IDLE;
      end
   end

   // State flop
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= div_pkg::IDLE;
      end else begin
         state <= next_state;
      end
   end

   // Step counter, parked at zero outside RUN
   always_ff @(posedge clk) begin
      if (reset || (state != div_pkg::RUN)) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Never leaves the six legal codes
   a_state_legal : assert property (@(posedge clk) disable iff (reset)
      state inside {div_pkg::IDLE, div_pkg::RUN, div_pkg::LAST_CALC,
                    div_pkg::CHK_OVFL, div_pkg::FIX_OVFL, div_pkg::DONE});

   // Request holds until ack or kill
   a_req_hold : assert property (@(posedge clk) disable iff (reset)
      (result_req && !result_ack && !kill) |=> result_req);

endmodule

// ==== src/div_pkg.sv ====
/*
 * Divider types
 * State encoding and the request, raw and final result records
 */
`include "div_cfg.svh"

package div_pkg;

   // One-hot sequencer states
   typedef enum logic [5:0] {
      IDLE      = 6'b000001,
      RUN       = 6'b000010,
      LAST_CALC = 6'b000100,
      CHK_OVFL  = 6'b001000,
      FIX_OVFL  = 6'b010000,
      DONE      = 6'b100000
   } div_state_e;

   // Operation issued by the caller
   typedef struct packed {
      logic [`DIV_DIVIDEND_W-1:0] dividend;
      logic [`DIV_DIVISOR_W-1:0]  divisor;
      logic                       signed_div;
   } div_req_t;

   // Sign-corrected full-width quotient
   typedef struct packed {
      logic [`DIV_DIVIDEND_W-1:0] quotient;
      logic                       signed_div;
   } div_raw_t;

   // Saturated quotient and icc {N, Z, V, C}
   typedef struct packed {
      logic [`DIV_QUOT_W-1:0] quotient;
      logic [3:0]             icc;
   } div_result_t;

endpackage

// ==== src/div_cfg.svh ====
/*
 * Divider configuration
 * Operand widths, iteration count and pipeline latency
 */
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand and result widths
`define DIV_DIVIDEND_W 64
`define DIV_DIVISOR_W  32
`define DIV_QUOT_W     32

// One restoring step per dividend bit
`define DIV_STEPS      64

// Accepting edge to first result_req cycle
// load, 64 x RUN, LAST_CALC, CHK_OVFL, FIX_OVFL
`define DIV_LATENCY    68

`endif
